// ==== tb.f ====
+incdir+hdl
hdl/bridge_pkg.sv
hdl/index_tracker.sv
hdl/reset_sequencer.sv
hdl/grant_ctrl.sv
hdl/wb_bus_master.sv
hdl/cpu_bridge.sv
test/tb_cpu_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu_bridge testbench, exit status is the verdict
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_cpu_bridge -o sim_tb_cpu_bridge &&
  ./obj_dir/sim_tb_cpu_bridge ||
  exit 1

// ==== test/tb_cpu_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module tb_cpu_bridge;

  // cycle budget per test
  // watchdog allows four times the sum
  localparam int TEST_CYCLES = 12 + 2 * 60 + 12 + 2 * 40 + 24;
  localparam int WATCH_NS    = TEST_CYCLES * 4 * 8;

  logic                      clk;
  logic                      ext_rst_b;
  bridge_pkg::ring_in_t      ring_in;
  bridge_pkg::ring_out_t     ring_out;
  bridge_pkg::core_state_e   core_state;
  bridge_pkg::core_req_t     core_req;
  bridge_pkg::core_rsp_t     core_rsp;
  logic                      next_state;
  logic                      core_rst;
  logic                      ext_rst_e;
  logic [`BRIDGE_ADDR_W-1:0] base_addr;
  logic [`BRIDGE_ADDR_W-1:0] base_addr_data;
  bridge_pkg::wb_m2s_t       wb_m2s;
  bridge_pkg::wb_s2m_t       wb_s2m;
  bridge_pkg::ind_rel_e      cpu_ind_rel;

  // checker state
  logic                      armed;
  logic                      rerun;
  logic [2:0]                seq_edge;
  logic                      cold_seq;
  bridge_pkg::cpu_index_t    exp_own;
  bridge_pkg::cpu_index_t    own_nxt;
  bridge_pkg::ind_rel_e      exp_rel;
  logic [`BRIDGE_ADDR_W-1:0] exp_base;
  logic [`BRIDGE_ADDR_W-1:0] exp_base_data;
  logic [31:0]               rng_state;
  logic                      seq_done;
  logic                      offer;
  logic                      offer_eq;

  cpu_bridge dut0 (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .ring_in        (ring_in),
    .ring_out       (ring_out),
    .core_state     (core_state),
    .core_req       (core_req),
    .core_rsp       (core_rsp),
    .next_state     (next_state),
    .core_rst       (core_rst),
    .ext_rst_e      (ext_rst_e),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .wb_m2s         (wb_m2s),
    .wb_s2m         (wb_s2m),
    .cpu_ind_rel    (cpu_ind_rel)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift(rng_state);
    r = rng_state;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("** Error: %s expected %0h actual %0h", name, exp, act);
    $display("Errors found");
    $fatal(1, "check failed");
  endtask

  // sequence step and own index as the ring rules predict them
  always @(posedge clk) begin
    if (ext_rst_b) begin
      seq_edge <= '0;
      cold_seq <= 1'b1;
      exp_own  <= '0;
    end else if (rerun) begin
      seq_edge <= '0;
      cold_seq <= 1'b0;
      exp_own  <= '0;
    end else begin
      if (seq_edge < 3'd7) begin
        seq_edge <= seq_edge + 3'd1;
      end
      own_nxt = exp_own;
      if (core_state == bridge_pkg::start_begin) begin
        own_nxt.active = 1'b1;
      end
      if (ring_in.cpu_index.pos != exp_own.pos) begin
        // lower active cpu left so we slide down
        if (ring_in.msg == bridge_pkg::msg_end && ring_in.cpu_index.active &&
            exp_own.active && ring_in.cpu_index.pos < exp_own.pos) begin
          own_nxt.pos = exp_own.pos - 31'd1;
        end else if (ring_in.msg == bridge_pkg::msg_start &&
                     !ring_in.cpu_index.active) begin
          own_nxt.pos = exp_own.active ? exp_own.pos + 31'd1 : exp_own.pos - 31'd1;
        end
      end
      // step 3 takes the ring index on a cold start
      if (seq_edge == 3'd2 && cold_seq) begin
        own_nxt = ring_in.cpu_index;
      end
      exp_own <= own_nxt;
    end
  end

  assign seq_done = seq_edge >= 3'd5;
  assign offer    = ring_in.next_q && seq_done;
  assign offer_eq = offer && ring_in.cpu_index.pos == exp_own.pos;

  always_comb begin
    if (ring_in.cpu_index.pos < exp_own.pos) begin
      exp_rel = bridge_pkg::rel_less;
    end else if (ring_in.cpu_index.pos > exp_own.pos) begin
      exp_rel = bridge_pkg::rel_greater;
    end else begin
      exp_rel = bridge_pkg::rel_equal;
    end
  end

  // reset sequence
  a_core_rst: assert property (@(posedge clk) disable iff (!armed)
    core_rst == (seq_edge == 3'd4))
    else report_mismatch("reset core_rst", 64'($sampled(seq_edge == 3'd4)),
                         64'($sampled(core_rst)));
  a_reset_msg: assert property (@(posedge clk) disable iff (!armed)
    (ring_out.msg == bridge_pkg::msg_reset) == (seq_edge == 3'd3 && cold_seq))
    else report_mismatch("reset message", 64'($sampled(seq_edge == 3'd3 && cold_seq)),
                         64'($sampled(ring_out.msg)));
  a_quiet: assert property (@(posedge clk) disable iff (!armed)
    seq_edge < 3'd5 |-> !ring_out.next_e && !wb_m2s.cyc && !wb_m2s.stb && !next_state &&
      cpu_ind_rel == bridge_pkg::rel_none)
    else report_mismatch("reset quiet outputs", 64'(0),
                         64'($sampled({ring_out.next_e, wb_m2s.cyc, wb_m2s.stb,
                                       next_state, cpu_ind_rel})));
  // outside reset ack is clear once the sequence is over
  a_ext_rst_e: assert property (@(posedge clk) disable iff (!armed)
    seq_done |-> !ext_rst_e)
    else report_mismatch("reset ext_rst_e", 64'(0), 64'($sampled(ext_rst_e)));

  // index relation one edge after each offer
  a_rel: assert property (@(posedge clk) disable iff (!armed)
    $past(offer) |-> cpu_ind_rel == $past(exp_rel))
    else report_mismatch("index relation", 64'($past(exp_rel)),
                         64'($sampled(cpu_ind_rel)));

  // thread start and finish two edges after the offer
  a_start: assert property (@(posedge clk) disable iff (!armed)
    $past(offer_eq && core_state == bridge_pkg::wait_for_start, 2) |->
      ring_out.next_e && next_state && ring_out.msg == bridge_pkg::msg_start)
    else report_mismatch("thread start", 64'({1'b1, 1'b1, bridge_pkg::msg_start}),
                         64'($sampled({ring_out.next_e, next_state, ring_out.msg})));
  a_base: assert property (@(posedge clk) disable iff (!armed)
    $past(offer_eq && core_state == bridge_pkg::wait_for_start, 2) |->
      base_addr == exp_base && base_addr_data == exp_base_data)
    else report_mismatch("thread base", {exp_base, exp_base_data},
                         $sampled({base_addr, base_addr_data}));
  a_end: assert property (@(posedge clk) disable iff (!armed)
    $past(offer_eq && core_state == bridge_pkg::finish_begin, 2) |->
      ring_out.next_e && next_state && ring_out.msg == bridge_pkg::msg_end)
    else report_mismatch("thread finish", 64'({1'b1, 1'b1, bridge_pkg::msg_end}),
                         64'($sampled({ring_out.next_e, next_state, ring_out.msg})));
  a_one_cycle: assert property (@(posedge clk) disable iff (!armed)
    $past(offer_eq && (core_state == bridge_pkg::wait_for_start ||
                       core_state == bridge_pkg::finish_begin), 3) |->
      !ring_out.next_e && !next_state && ring_out.msg == bridge_pkg::msg_void)
    else report_mismatch("one-cycle outputs", 64'(0),
                         64'($sampled({ring_out.next_e, next_state, ring_out.msg})));

  // wishbone gating
  a_cyc_gated: assert property (@(posedge clk) disable iff (!armed)
    wb_m2s.cyc |-> cpu_ind_rel == bridge_pkg::rel_equal)
    else report_mismatch("bus gated", 64'(bridge_pkg::rel_equal),
                         64'($sampled(cpu_ind_rel)));
  a_cyc_req: assert property (@(posedge clk) disable iff (!armed)
    wb_m2s.cyc |-> wb_m2s.stb && wb_m2s.adr == core_req.addr &&
      wb_m2s.we == core_req.write && (!core_req.write || wb_m2s.dat == core_req.wdata))
    else report_mismatch("bus request", 64'($sampled(core_req.addr)),
                         64'($sampled(wb_m2s.adr)));
  a_cyc_stable: assert property (@(posedge clk) disable iff (!armed)
    wb_m2s.cyc && $past(wb_m2s.cyc) |->
      $stable(wb_m2s.adr) && $stable(wb_m2s.we) && $stable(wb_m2s.dat))
    else report_mismatch("bus stable", 64'($past(wb_m2s.adr)),
                         64'($sampled(wb_m2s.adr)));
  a_rdata: assert property (@(posedge clk) disable iff (!armed)
    core_rsp.done |-> core_rsp.rdata == $past(wb_s2m.dat))
    else report_mismatch("bus read data", 64'($past(wb_s2m.dat)),
                         64'($sampled(core_rsp.rdata)));
  a_release: assert property (@(posedge clk) disable iff (!armed)
    core_rsp.done |=> ring_out.next_e)
    else report_mismatch("bus release", 64'(1), 64'($sampled(ring_out.next_e)));

  task automatic offer_grant();
    ring_in.cpu_index = exp_own;
    ring_in.next_q    = 1'b1;
    tick();
    ring_in.next_q    = 1'b0;
  endtask

  // random START and END from other cpus with an unequal offer after each
  task automatic send_msgs(input int n);
    logic [31:0]            r;
    bridge_pkg::cpu_index_t s;
    for (int i = 0; i < n; i++) begin
      next_rand(r);
      s.active = r[0];
      s.pos    = r[1] ? exp_own.pos + 31'(r[8:4]) + 31'd1 : exp_own.pos - 31'(r[8:4]) - 31'd1;
      ring_in.cpu_index = s;
      ring_in.msg = r[2] ? bridge_pkg::msg_start : bridge_pkg::msg_end;
      tick();
      ring_in.msg = bridge_pkg::msg_void;
      tick();
      next_rand(r);
      ring_in.cpu_index.pos = r[0] ? exp_own.pos + 31'(r[5:1]) + 31'd1
                                   : exp_own.pos - 31'(r[5:1]) - 31'd1;
      ring_in.next_q = 1'b1;
      tick();
      ring_in.next_q = 1'b0;
      tick();
    end
  endtask

  task automatic thread_start();
    logic [31:0] r;
    core_state = bridge_pkg::wait_for_start;
    next_rand(r);
    core_req.addr = r;
    next_rand(r);
    // zero data puts the data area behind the code
    core_req.wdata = r[0] ? 32'd0 : r;
    exp_base      = core_req.addr + `BRIDGE_ADDR_W'(`BRIDGE_THREAD_HDR);
    exp_base_data = (core_req.wdata == 32'd0 ? core_req.addr : core_req.wdata) +
                    `BRIDGE_ADDR_W'(`BRIDGE_THREAD_HDR);
    offer_grant();
    while (!next_state) tick();
    core_state = bridge_pkg::start_begin;
    tick();
    core_state = bridge_pkg::alu;
    repeat (3) tick();
  endtask

  // request pends ungranted before the slave acks after a random delay
  task automatic bus_access(input logic wr);
    logic [31:0] r;
    core_state = wr ? bridge_pkg::write_phase : bridge_pkg::read_phase;
    next_rand(r);
    core_req.addr = r;
    next_rand(r);
    core_req.wdata = r;
    core_req.read  = !wr;
    core_req.write = wr;
    repeat (3) tick();
    offer_grant();
    while (!wb_m2s.cyc) tick();
    next_rand(r);
    repeat (int'(r[1:0])) tick();
    next_rand(r);
    wb_s2m.dat = r;
    wb_s2m.ack = 1'b1;
    tick();
    wb_s2m.ack = 1'b0;
    while (!core_rsp.done) tick();
    core_req.read  = 1'b0;
    core_req.write = 1'b0;
    core_state = bridge_pkg::alu;
    repeat (3) tick();
  endtask

  task automatic thread_finish();
    core_state = bridge_pkg::finish_begin;
    offer_grant();
    while (!next_state) tick();
    tick();
    // no grant now so the sequence runs again
    core_state = bridge_pkg::finish_end;
    rerun = 1'b1;
    tick();
    rerun = 1'b0;
    while (!core_rst) tick();
    core_state = bridge_pkg::wait_for_start;
    repeat (4) tick();
  endtask

  initial begin
    #(WATCH_NS);
    $display("Errors found");
    $fatal(1, "watchdog expired before the tests finished");
  end

  initial begin
    logic [31:0] r;
    rng_state  = 32'd6;
    armed      = 1'b0;
    rerun      = 1'b0;
    ext_rst_b  = 1'b1;
    ring_in    = '0;
    core_state = bridge_pkg::wait_for_start;
    core_req   = '0;
    wb_s2m     = '0;
    exp_base      = '0;
    exp_base_data = '0;
    tick();
    armed = 1'b1;
    // index the sequencer loads at step 3
    next_rand(r);
    ring_in.cpu_index.active = 1'b0;
    ring_in.cpu_index.pos    = 31'd100 + 31'(r[5:0]);
    tick();
    ext_rst_b = 1'b0;
    repeat (3) tick();
    // grant offer in the middle of the sequence goes unheard
    offer_grant();
    repeat (3) tick();
    send_msgs(6);
    thread_start();
    bus_access(1'b0);
    bus_access(1'b1);
    send_msgs(6);
    thread_finish();
    $display("No errors");
    $finish;
  end

endmodule

// ==== hdl/cpu_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module cpu_bridge (
  input  logic                      clk,
  input  logic                      ext_rst_b,
  input  bridge_pkg::ring_in_t      ring_in,
  output bridge_pkg::ring_out_t     ring_out,
  input  bridge_pkg::core_state_e   core_state,
  input  bridge_pkg::core_req_t     core_req,
  output bridge_pkg::core_rsp_t     core_rsp,
  output logic                      next_state,
  output logic                      core_rst,
  output logic                      ext_rst_e,
  output logic [`BRIDGE_ADDR_W-1:0] base_addr,
  output logic [`BRIDGE_ADDR_W-1:0] base_addr_data,
  output bridge_pkg::wb_m2s_t       wb_m2s,
  input  bridge_pkg::wb_s2m_t       wb_s2m,
  output bridge_pkg::ind_rel_e      cpu_ind_rel
);

  logic                 load;
  logic                 restart;
  logic                 own_clear;
  logic                 reset_msg;
  logic                 running;
  logic                 online;
  bridge_pkg::ring_in_t ring_seen;

  // grant offers are ignored until the reset sequence is over
  // messages and the index itself still pass
  always_comb begin
    ring_seen        = ring_in;
    ring_seen.next_q = ring_in.next_q && running;
  end

  reset_sequencer u_seq (
    .clk        (clk),
    .ext_rst_b  (ext_rst_b),
    .core_state (core_state),
    .restart    (restart),
    .load       (load),
    .core_rst   (core_rst),
    .ext_rst_e  (ext_rst_e),
    .reset_msg  (reset_msg),
    .running    (running)
  );

  // compare stage, own index stays inside the tracker
  index_tracker u_idx (
    .clk        (clk),
    .ext_rst_b  (ext_rst_b),
    .ring_in    (ring_seen),
    .load       (load),
    .own_clear  (own_clear),
    .core_state (core_state),
    .released   (ring_out.next_e),
    .own_index  (),
    .ind_rel    (cpu_ind_rel)
  );

  // grant stage
  grant_ctrl u_grant (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .running        (running),
    .ind_rel        (cpu_ind_rel),
    .core_state     (core_state),
    .core_req       (core_req),
    .bus_done       (core_rsp.done),
    .reset_msg      (reset_msg),
    .online         (online),
    .ring_out       (ring_out),
    .next_state     (next_state),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .restart        (restart),
    .own_clear      (own_clear)
  );

  // bus stage
  wb_bus_master u_wb (
    .clk        (clk),
    .ext_rst_b  (ext_rst_b),
    .online     (online),
    .core_state (core_state),
    .core_req   (core_req),
    .wb_s2m     (wb_s2m),
    .wb_m2s     (wb_m2s),
    .core_rsp   (core_rsp)
  );

endmodule

// ==== hdl/wb_bus_master.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module wb_bus_master (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  logic                    online,
  input  bridge_pkg::core_state_e core_state,
  input  bridge_pkg::core_req_t   core_req,
  input  bridge_pkg::wb_s2m_t     wb_s2m,
  output bridge_pkg::wb_m2s_t     wb_m2s,
  output bridge_pkg::core_rsp_t   core_rsp
);

  logic                      cyc_q;
  logic                      done_q;
  // one access per grant
  logic                      served_q;
  logic                      we_q;
  logic [`BRIDGE_ADDR_W-1:0] adr_q;
  logic [`BRIDGE_DATA_W-1:0] dat_q;
  logic [`BRIDGE_DATA_W-1:0] rdata_q;
  logic                      bus_phase;
  logic                      launch;
  logic                      finish;

  assign bus_phase = core_state == bridge_pkg::read_phase ||
                     core_state == bridge_pkg::write_phase;
  // open a cycle only while holding the grant
  assign launch = online && bus_phase && (core_req.read || core_req.write) &&
                  !cyc_q && !done_q && !served_q;
  // ack closes the cycle on this edge
  assign finish = cyc_q && wb_s2m.ack;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cyc_q    <= 1'b0;
      done_q   <= 1'b0;
      served_q <= 1'b0;
    end else begin
      done_q <= finish;
      if (launch) begin
        cyc_q <= 1'b1;
      end else if (finish) begin
        cyc_q    <= 1'b0;
        served_q <= 1'b1;
      end
      // grant gone, ready for the next one
      if (!online) begin
        served_q <= 1'b0;
      end
    end
  end

  // address and data held stable for the whole cycle
  always_ff @(posedge clk) begin
    if (launch) begin
      we_q  <= core_req.write;
      adr_q <= core_req.addr;
      dat_q <= core_req.wdata;
    end
    if (finish) begin
      rdata_q <= wb_s2m.dat;
    end
  end

  assign wb_m2s.cyc = cyc_q;
  assign wb_m2s.stb = cyc_q;
  assign wb_m2s.we  = we_q;
  assign wb_m2s.adr = adr_q;
  assign wb_m2s.dat = dat_q;

  assign core_rsp.done  = done_q;
  assign core_rsp.rdata = rdata_q;

endmodule

// ==== hdl/grant_ctrl.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module grant_ctrl (
  input  logic                      clk,
  input  logic                      ext_rst_b,
  input  logic                      running,
  input  bridge_pkg::ind_rel_e      ind_rel,
  input  bridge_pkg::core_state_e   core_state,
  input  bridge_pkg::core_req_t     core_req,
  input  logic                      bus_done,
  input  logic                      reset_msg,
  output logic                      online,
  output bridge_pkg::ring_out_t     ring_out,
  output logic                      next_state,
  output logic [`BRIDGE_ADDR_W-1:0] base_addr,
  output logic [`BRIDGE_ADDR_W-1:0] base_addr_data,
  output logic                      restart,
  output logic                      own_clear
);

  logic                      granted;
  logic                      take;
  logic                      next_e_q;
  bridge_pkg::ring_msg_e     msg_q;
  logic [`BRIDGE_ADDR_W-1:0] data_base;

  // the ring named us and the sequence is over
  assign granted = running && ind_rel == bridge_pkg::rel_equal;
  // act once per grant, not again while releasing
  assign take = granted && !online && !next_e_q;

  // zero data means the data area follows the code area
  assign data_base = core_req.wdata == '0 ? core_req.addr : core_req.wdata;

  // thread done and no grant pending, start over
  assign restart   = running && !granted && !online &&
                     core_state == bridge_pkg::finish_end;
  assign own_clear = restart;

  // reset message from the sequencer shares the ring output
  assign ring_out.next_e = next_e_q;
  assign ring_out.msg    = reset_msg ? bridge_pkg::msg_reset : msg_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      online     <= 1'b0;
      next_e_q   <= 1'b0;
      next_state <= 1'b0;
      msg_q      <= bridge_pkg::msg_void;
    end else begin
      // one-cycle outputs by default
      next_e_q   <= 1'b0;
      next_state <= 1'b0;
      msg_q      <= bridge_pkg::msg_void;
      // grant handed back
      if (next_e_q) begin
        online <= 1'b0;
      end
      if (take) begin
        online <= 1'b1;
        case (core_state)
          bridge_pkg::wait_for_start: begin
            next_e_q   <= 1'b1;
            next_state <= 1'b1;
            msg_q      <= bridge_pkg::msg_start;
          end
          bridge_pkg::finish_begin: begin
            next_e_q   <= 1'b1;
            next_state <= 1'b1;
            msg_q      <= bridge_pkg::msg_end;
          end
          default: begin
            // bus access, release once the bus master is done
          end
        endcase
      end else if (online && bus_done) begin
        next_e_q <= 1'b1;
      end
    end
  end

  // thread base addresses, taken when the thread starts
  always_ff @(posedge clk) begin
    if (take && core_state == bridge_pkg::wait_for_start) begin
      base_addr      <= core_req.addr + `BRIDGE_ADDR_W'(`BRIDGE_THREAD_HDR);
      base_addr_data <= data_base + `BRIDGE_ADDR_W'(`BRIDGE_THREAD_HDR);
    end
  end

endmodule

// ==== hdl/reset_sequencer.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module reset_sequencer (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  bridge_pkg::core_state_e core_state,
  input  logic                    restart,
  output logic                    load,
  output logic                    core_rst,
  output logic                    ext_rst_e,
  output logic                    reset_msg,
  output logic                    running
);

  localparam int unsigned CNT_W      = $clog2(`BRIDGE_RESET_STEPS + 1);
  localparam int unsigned LOAD_STEP  = `BRIDGE_RESET_STEPS - 2;
  localparam int unsigned PULSE_STEP = `BRIDGE_RESET_STEPS - 1;

  // edges seen since reset release or restart
  logic [CNT_W-1:0] step_cnt;
  // step number of the coming edge
  logic [CNT_W-1:0] cur_step;
  logic             in_finish;
  logic             pulse_step;

  assign cur_step   = step_cnt + 1'b1;
  assign in_finish  = core_state == bridge_pkg::finish_end;
  assign pulse_step = cur_step == CNT_W'(PULSE_STEP);

  // sequence done, ring grants are honored from here on
  assign running = step_cnt == CNT_W'(`BRIDGE_RESET_STEPS);

  // tracker picks up the ring index on this edge
  // after a finished thread the index was already cleared
  assign load = cur_step == CNT_W'(LOAD_STEP) && !in_finish;

  always_ff @(posedge clk) begin
    if (ext_rst_b || restart) begin
      step_cnt  <= '0;
      reset_msg <= 1'b0;
      core_rst  <= 1'b0;
      ext_rst_e <= 1'b0;
    end else begin
      // counter parks at the last step
      if (!running) begin
        step_cnt <= cur_step;
      end
      // reset message rides the cycle after the load
      reset_msg <= load;
      // one-cycle core reset
      core_rst  <= pulse_step;
      // outside reset ack only on a cold start
      ext_rst_e <= pulse_step && !in_finish;
    end
  end

endmodule

// ==== hdl/index_tracker.sv ====
`timescale 1ns/1ps

module index_tracker (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  bridge_pkg::ring_in_t    ring_in,
  input  logic                    load,
  input  logic                    own_clear,
  input  bridge_pkg::core_state_e core_state,
  input  logic                    released,
  output bridge_pkg::cpu_index_t  own_index,
  output bridge_pkg::ind_rel_e    ind_rel
);

  logic                   other_sender;
  logic                   end_below;
  logic                   start_idle;
  bridge_pkg::cpu_index_t own_next;

  // our own messages come back on the ring, skip them
  assign other_sender = ring_in.cpu_index != own_index;

  // an active cpu ahead of us ended its thread
  // so the active group shrinks below us
  assign end_below = ring_in.msg == bridge_pkg::msg_end &&
                     ring_in.cpu_index.active &&
                     own_index.active &&
                     ring_in.cpu_index.pos < own_index.pos;

  // an idle cpu started a thread
  assign start_idle = ring_in.msg == bridge_pkg::msg_start &&
                      !ring_in.cpu_index.active;

  // next own index
  always_comb begin
    own_next = own_index;
    // thread began on our core
    if (core_state == bridge_pkg::start_begin) begin
      own_next.active = 1'b1;
    end
    if (other_sender && end_below) begin
      own_next.pos = own_index.pos - 1'b1;
    end else if (other_sender && start_idle) begin
      // active cpus move up, idle ones move down
      if (own_index.active) begin
        own_next.pos = own_index.pos + 1'b1;
      end else begin
        own_next.pos = own_index.pos - 1'b1;
      end
    end
    // thread over, back to nonactive zero
    if (own_clear) begin
      own_next = '0;
    end
    // initial index comes from the ring during the reset sequence
    if (load) begin
      own_next = ring_in.cpu_index;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_index <= '0;
    end else begin
      own_index <= own_next;
    end
  end

  // relation latched on the grant offer
  // held until the bridge lets the grant go
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ind_rel <= bridge_pkg::rel_none;
    end else if (ring_in.next_q) begin
      if (ring_in.cpu_index.pos < own_index.pos) begin
        ind_rel <= bridge_pkg::rel_less;
      end else if (ring_in.cpu_index.pos > own_index.pos) begin
        ind_rel <= bridge_pkg::rel_greater;
      end else begin
        ind_rel <= bridge_pkg::rel_equal;
      end
    end else if (released) begin
      ind_rel <= bridge_pkg::rel_none;
    end
  end

endmodule

// ==== hdl/bridge_pkg.sv ====
`include "bridge_defs.svh"

package bridge_pkg;

  // phase the core reports to its bridge
  typedef enum logic [2:0] {
    wait_for_start = 3'd0,
    start_begin    = 3'd1,
    read_phase     = 3'd2,
    write_phase    = 3'd3,
    alu            = 3'd4,
    finish_begin   = 3'd5,
    finish_end     = 3'd6
  } core_state_e;

  // ring message opcodes, void means no message
  typedef enum logic [1:0] {
    msg_void  = 2'd0,
    msg_reset = 2'd1,
    msg_start = 2'd2,
    msg_end   = 2'd3
  } ring_msg_e;

  // broadcast index compared to own index
  typedef enum logic [1:0] {
    rel_none    = 2'd0,
    rel_less    = 2'd1,
    rel_greater = 2'd2,
    rel_equal   = 2'd3
  } ind_rel_e;

  // position on the ring plus running-thread flag
  typedef struct packed {
    logic                     active;
    logic [`BRIDGE_POS_W-1:0] pos;
  } cpu_index_t;

  // from the ring: grant offer, candidate or sender index, message
  typedef struct packed {
    logic       next_q;
    cpu_index_t cpu_index;
    ring_msg_e  msg;
  } ring_in_t;

  // to the ring: release and message
  typedef struct packed {
    logic      next_e;
    ring_msg_e msg;
  } ring_out_t;

  // core memory request, held until done
  typedef struct packed {
    logic                      read;
    logic                      write;
    logic [`BRIDGE_ADDR_W-1:0] addr;
    logic [`BRIDGE_DATA_W-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic                      done;
    logic [`BRIDGE_DATA_W-1:0] rdata;
  } core_rsp_t;

  // wishbone classic master outputs
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`BRIDGE_ADDR_W-1:0] adr;
    logic [`BRIDGE_DATA_W-1:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic                      ack;
    logic [`BRIDGE_DATA_W-1:0] dat;
  } wb_s2m_t;

endpackage

// ==== hdl/bridge_defs.svh ====
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// external bus address width
`define BRIDGE_ADDR_W 32

// external bus data width
`define BRIDGE_DATA_W 32

// ring position, the active flag sits on top of it
`define BRIDGE_POS_W 31

// room kept in front of a thread's code and data
`define BRIDGE_THREAD_HDR 16

// edges counted by the sequencer after reset release
// load on steps-2, core reset on steps-1, done on steps
`define BRIDGE_RESET_STEPS 5

`endif
